// File: quplsDecodeTop.f
rtl/quplsDecodePkg.sv
rtl/quplsPipeReg.sv
rtl/quplsFetch.sv
rtl/quplsDecodeRt.sv
rtl/quplsDecodeRs.sv
rtl/quplsDecodeStage.sv
rtl/quplsDecodeTop.sv
tb/quplsDecodeTb.sv

// File: runSim.sh
#!/bin/sh
# Compile the front end testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps \
	--top-module quplsDecodeTb -Mdir obj_dir -f quplsDecodeTop.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/VquplsDecodeTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

// File: tb/quplsDecodeTb.sv
// Testbench for the fetch and decode front end
// Clock, reset and a Wishbone memory model with random wait states
// Downstream ready driver with long stall stretches
// Reference model of the target and source decode rules
// Directed tests for reset, target decode, banking and back-pressure

`timescale 1ns/100ps

module quplsDecodeTb
	import quplsDecodePkg::*;
();

	logic            clk = 1'b0;
	logic            rstN;
	operating_mode_t om;
	logic [2:0]      ipl;
	logic            wbCyc;
	logic            wbStb;
	logic            wbWe;
	logic [3:0]      wbSel;
	logic [31:0]     wbAdr;
	logic [31:0]     wbDatI = 32'd0;
	logic            wbAck = 1'b0;
	logic            decValid;
	logic            decReady = 1'b1;
	decodePkt_t      decPkt;

	// Instruction memory holds one word per address divided by 4
	logic [31:0] mem [0:255];
	// Program of the current test and the packets it produced
	logic [31:0] prog [$];
	decodePkt_t  gotPkts [$];

	int seed = 19319;
	int waitLeft = 0;
	bit inCycle = 1'b0;
	int holdLeft = 0;
	bit stallMode = 1'b0;
	int errorCount = 0;
	int checkCount = 0;

	always #4 clk = ~clk;

	quplsDecodeTop quplsDecodeTop_inst (
		.clk(clk),
		.rstN(rstN),
		.om(om),
		.ipl(ipl),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbSel(wbSel),
		.wbAdr(wbAdr),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.decValid(decValid),
		.decReady(decReady),
		.decPkt(decPkt)
	);

	// ==============================
	// Bus slave and downstream model
	// ==============================

	// Both share one random stream so the run repeats exactly
	always @(posedge clk)
	begin
		if (!rstN)
		begin
			wbAck <= 1'b0;
			inCycle = 1'b0;
		end
		else if (wbAck)
			wbAck <= 1'b0;
		else if (wbCyc && wbStb)
		begin
			// A new cycle draws its wait state count once
			if (!inCycle)
				waitLeft = $unsigned($random(seed)) % 4;
			inCycle = 1'b1;
			if (waitLeft == 0)
			begin
				wbAck <= 1'b1;
				wbDatI <= mem[wbAdr[9:2]];
				inCycle = 1'b0;
			end
			else
				waitLeft = waitLeft - 1;
		end
		// Ready stays high unless a test asks for stalls
		if (!stallMode)
			decReady <= 1'b1;
		else if (holdLeft > 0)
			holdLeft = holdLeft - 1;
		else
		begin
			decReady <= !decReady;
			// Low stretches last up to ten cycles, high ones one or two
			holdLeft = decReady ? $unsigned($random(seed)) % 10 : $unsigned($random(seed)) % 2;
		end
	end

	// ==============================
	// Decode reference model
	// ==============================

	function automatic logic [31:0] makeInstr(input logic [6:0] op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb, input logic [6:0] fn);
		return {fn, 3'b000, rb, ra, rt, op};
	endfunction

	// Register 31 goes to 32 plus ipl in mode 3, else to 40 plus mode
	function automatic aregno_t bankedNumber(input logic [4:0] field,
		input operating_mode_t omVal, input logic [2:0] iplVal);
		if (field != 5'd31)
			return {1'b0, field};
		if (omVal == 2'd3)
			return 6'd32 + {3'd0, iplVal};
		return 6'd40 + {4'd0, omVal};
	endfunction

	function automatic bit knownFunc(input logic [6:0] fn);
		case (fn)
		FN_ADD, FN_SUB, FN_AND, FN_OR, FN_EOR, FN_SLT, FN_MUL:
			return 1'b1;
		default:
			return 1'b0;
		endcase
	endfunction

	// Returns the written register field and 0 when nothing is written
	function automatic logic [4:0] targetField(input logic [31:0] word);
		logic [6:0] op;
		op = word[6:0];
		if (op == OP_R2)
			return knownFunc(word[31:25]) ? word[11:7] : 5'd0;
		if (op == OP_ADDI || op == OP_ANDI || op == OP_ORI || op == OP_LDO || op == OP_BSR)
			return word[11:7];
		// Bit 7 is the decrement flag of a conditional branch
		if (op == OP_BCC)
			return word[7] ? word[16:12] : 5'd0;
		if (op == OP_RTD)
			return 5'd31;
		return 5'd0;
	endfunction

	function automatic decodePkt_t modelPacket(input logic [31:0] pc, input logic [31:0] word,
		input operating_mode_t omVal, input logic [2:0] iplVal);
		decodePkt_t pkt;
		logic [6:0] op;
		logic [4:0] rbField;
		op = word[6:0];
		pkt.pc = pc;
		pkt.opcode = opcode_t'(op);
		pkt.rt = bankedNumber(targetField(word), omVal, iplVal);
		pkt.rtz = (pkt.rt == 6'd0);
		pkt.usesRa = !(op == OP_NOP || op == OP_BSR || op == OP_RTD);
		pkt.usesRb = (op == OP_R2 || op == OP_STO);
		// Stores read their data register from the rt field
		rbField = (op == OP_STO) ? word[11:7] : word[21:17];
		pkt.ra = pkt.usesRa ? bankedNumber(word[16:12], omVal, iplVal) : 6'd0;
		pkt.rb = pkt.usesRb ? bankedNumber(rbField, omVal, iplVal) : 6'd0;
		return pkt;
	endfunction

	// ==============================
	// Test helpers
	// ==============================

	task automatic checkValue(input string testName, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("CHECK FAILED %s expected %h actual %h at %0t", testName, expected,
				actual, $time);
		end
	endtask

	// Words past the program decode as no-ops with address dependent fields
	task automatic loadMemory();
		int i;
		for (i = 0; i < 256; i++)
			mem[i] = {i[24:0], OP_NOP};
		for (i = 0; i < prog.size(); i++)
			mem[i] = prog[i];
	endtask

	task automatic applyReset(input string name, input operating_mode_t omVal,
		input logic [2:0] iplVal);
		@(posedge clk);
		rstN <= 1'b0;
		om <= omVal;
		ipl <= iplVal;
		repeat (2)
		begin
			@(negedge clk);
			checkValue({name, " in reset"}, 64'd0, {61'd0, wbCyc, wbStb, decValid});
			@(posedge clk);
		end
		rstN <= 1'b1;
		@(negedge clk);
		checkValue({name, " after reset"}, 64'd0, {61'd0, wbCyc, wbStb, decValid});
	endtask

	// Packets are sampled at the falling edge, a transfer completes at the next rising edge
	task automatic runProgram(input string name, input operating_mode_t omVal,
		input logic [2:0] iplVal, input bit stall);
		decodePkt_t expected;
		decodePkt_t held;
		bit stalled;
		int got;
		int idle;
		loadMemory();
		stallMode = stall;
		gotPkts.delete();
		applyReset(name, omVal, iplVal);
		got = 0;
		idle = 0;
		stalled = 1'b0;
		while (got < prog.size() && idle < 60)
		begin
			@(negedge clk);
			// A stalled packet must still be valid and unchanged
			if (stalled)
				checkValue({name, " stall"}, {3'd0, 1'b1, held}, {3'd0, decValid, decPkt});
			stalled = decValid && !decReady;
			held = decPkt;
			if (decValid && decReady)
			begin
				expected = modelPacket(RESET_PC + 32'(4 * got), prog[got], omVal, iplVal);
				checkValue(name, {4'd0, expected}, {4'd0, decPkt});
				gotPkts.push_back(decPkt);
				got++;
				idle = 0;
			end
			else
				idle++;
		end
		if (got < prog.size())
		begin
			$display("Timeout in %s: only %0d of %0d packets arrived", name, got, prog.size());
			errorCount++;
		end
		stallMode = 1'b0;
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic resetState();
		int idle;
		prog.delete();
		prog.push_back(makeInstr(OP_NOP, 5'd0, 5'd0, 5'd0, 7'd0));
		loadMemory();
		applyReset("reset", 2'd0, 3'd0);
		idle = 0;
		while (!wbCyc && idle < 60)
		begin
			@(negedge clk);
			idle++;
		end
		if (!wbCyc)
		begin
			$display("Timeout: the fetch started no bus cycle after reset");
			errorCount++;
		end
		else
		begin
			checkValue("reset address", {32'd0, RESET_PC}, {32'd0, wbAdr});
			checkValue("reset write enable", 64'd0, {63'd0, wbWe});
			// A word fetch enables all four byte lanes
			checkValue("reset byte select", 64'hF, {60'd0, wbSel});
		end
	endtask

	task automatic aluTargets();
		prog.delete();
		prog.push_back(makeInstr(OP_R2, 5'd3, 5'd1, 5'd2, FN_ADD));
		prog.push_back(makeInstr(OP_R2, 5'd4, 5'd5, 5'd6, FN_SUB));
		prog.push_back(makeInstr(OP_R2, 5'd7, 5'd8, 5'd9, FN_AND));
		prog.push_back(makeInstr(OP_R2, 5'd10, 5'd11, 5'd12, FN_OR));
		prog.push_back(makeInstr(OP_R2, 5'd13, 5'd14, 5'd15, FN_EOR));
		prog.push_back(makeInstr(OP_R2, 5'd16, 5'd17, 5'd18, FN_SLT));
		prog.push_back(makeInstr(OP_R2, 5'd19, 5'd20, 5'd21, FN_MUL));
		// An unknown function code has no target
		prog.push_back(makeInstr(OP_R2, 5'd22, 5'd23, 5'd24, 7'd99));
		prog.push_back(makeInstr(OP_ADDI, 5'd25, 5'd26, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_ANDI, 5'd27, 5'd28, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_ORI, 5'd29, 5'd30, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_LDO, 5'd1, 5'd2, 5'd0, 7'd0));
		runProgram("aluTargets", 2'd0, 3'd0, 1'b0);
	endtask

	task automatic specialTargets();
		prog.delete();
		prog.push_back(makeInstr(OP_BCC, 5'd1, 5'd7, 5'd3, 7'd0));
		prog.push_back(makeInstr(OP_BCC, 5'd2, 5'd9, 5'd3, 7'd0));
		prog.push_back(makeInstr(OP_STO, 5'd9, 5'd4, 5'd12, 7'd0));
		prog.push_back(makeInstr(OP_RTD, 5'd0, 5'd0, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_NOP, 5'd5, 5'd6, 5'd7, 7'd0));
		prog.push_back(makeInstr(OP_BSR, 5'd29, 5'd0, 5'd0, 7'd0));
		prog.push_back(makeInstr(7'd50, 5'd6, 5'd8, 5'd10, 7'd0));
		runProgram("specialTargets", 2'd1, 3'd2, 1'b0);
	endtask

	task automatic bankCase(input operating_mode_t omVal, input logic [2:0] iplVal);
		string name;
		int spExpect;
		name = $sformatf("banking om=%0d ipl=%0d", omVal, iplVal);
		runProgram(name, omVal, iplVal, 1'b0);
		// Machine mode banks by level, the other modes by mode
		spExpect = (omVal == 2'd3) ? 32 + int'(iplVal) : 40 + int'(omVal);
		if (gotPkts.size() > 0)
			checkValue({name, " sp"}, 64'(spExpect), {58'd0, gotPkts[0].rt});
	endtask

	task automatic spBanking();
		prog.delete();
		prog.push_back(makeInstr(OP_R2, 5'd31, 5'd31, 5'd31, FN_ADD));
		prog.push_back(makeInstr(OP_ADDI, 5'd31, 5'd31, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_STO, 5'd31, 5'd31, 5'd5, 7'd0));
		prog.push_back(makeInstr(OP_BCC, 5'd1, 5'd31, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_RTD, 5'd0, 5'd0, 5'd0, 7'd0));
		bankCase(2'd0, 3'd0);
		bankCase(2'd1, 3'd0);
		bankCase(2'd2, 3'd0);
		bankCase(2'd3, 3'd0);
		bankCase(2'd3, 3'd5);
		bankCase(2'd3, 3'd7);
	endtask

	task automatic backPressure();
		prog.delete();
		prog.push_back(makeInstr(OP_ADDI, 5'd1, 5'd2, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_R2, 5'd3, 5'd4, 5'd5, FN_SUB));
		prog.push_back(makeInstr(OP_LDO, 5'd6, 5'd7, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_STO, 5'd8, 5'd9, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_BCC, 5'd1, 5'd10, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_ORI, 5'd11, 5'd12, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_R2, 5'd13, 5'd14, 5'd15, FN_MUL));
		prog.push_back(makeInstr(OP_BSR, 5'd30, 5'd0, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_ANDI, 5'd16, 5'd17, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_NOP, 5'd0, 5'd0, 5'd0, 7'd0));
		prog.push_back(makeInstr(OP_R2, 5'd18, 5'd19, 5'd20, FN_SLT));
		prog.push_back(makeInstr(OP_RTD, 5'd0, 5'd0, 5'd0, 7'd0));
		runProgram("backPressure", 2'd2, 3'd4, 1'b1);
	endtask

	initial
	begin
		rstN = 1'b0;
		om = 2'd0;
		ipl = 3'd0;
		resetState();
		aluTargets();
		specialTargets();
		spBanking();
		backPressure();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: rtl/quplsDecodeTop.sv
// Front end top level
// Fetch unit with its Wishbone port joined to the decode stage

`timescale 1ns/100ps

module quplsDecodeTop
	import quplsDecodePkg::*;
(
	input  logic            clk,
	input  logic            rstN,
	input  operating_mode_t om,
	input  logic [2:0]      ipl,
	output logic            wbCyc,
	output logic            wbStb,
	output logic            wbWe,
	output logic [3:0]      wbSel,
	output logic [31:0]     wbAdr,
	input  logic [31:0]     wbDatI,
	input  logic            wbAck,
	output logic            decValid,
	input  logic            decReady,
	output decodePkt_t      decPkt
);

	// Handshake between the fetch register and the decode stage
	logic      fetchValid;
	logic      fetchReady;
	fetchPkt_t fetchPkt;

	quplsFetch fetchUnit (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbSel(wbSel),
		.wbAdr(wbAdr),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.fetchValid(fetchValid),
		.fetchReady(fetchReady),
		.fetchPkt(fetchPkt)
	);

	quplsDecodeStage decodeUnit (
		.clk(clk),
		.rstN(rstN),
		.om(om),
		.ipl(ipl),
		.fetchValid(fetchValid),
		.fetchReady(fetchReady),
		.fetchPkt(fetchPkt),
		.decValid(decValid),
		.decReady(decReady),
		.decPkt(decPkt)
	);

endmodule

// File: rtl/quplsDecodeStage.sv
// Decode stage
// Target and source decoders feeding a registered decode packet
// Mode and level are captured with the packet

`timescale 1ns/100ps

module quplsDecodeStage
	import quplsDecodePkg::*;
(
	input  logic            clk,
	input  logic            rstN,
	input  operating_mode_t om,
	input  logic [2:0]      ipl,
	input  logic            fetchValid,
	output logic            fetchReady,
	input  fetchPkt_t       fetchPkt,
	output logic            decValid,
	input  logic            decReady,
	output decodePkt_t      decPkt
);

	decodePkt_t decIn;

	quplsDecodeRt rtDec (
		.om(om),
		.ipl(ipl),
		.instr(fetchPkt.instr),
		.rt(decIn.rt),
		.rtz(decIn.rtz)
	);

	quplsDecodeRs rsDec (
		.om(om),
		.ipl(ipl),
		.instr(fetchPkt.instr),
		.ra(decIn.ra),
		.rb(decIn.rb),
		.usesRa(decIn.usesRa),
		.usesRb(decIn.usesRb)
	);

	assign decIn.pc = fetchPkt.pc;
	assign decIn.opcode = fetchPkt.instr.opcode;

	// Banked numbers are frozen here, so a later mode change does not touch them
	quplsPipeReg #(
		.payloadT(decodePkt_t)
	) decReg (
		.clk(clk),
		.rstN(rstN),
		.inValid(fetchValid),
		.inReady(fetchReady),
		.inData(decIn),
		.outValid(decValid),
		.outReady(decReady),
		.outData(decPkt)
	);

endmodule

// File: rtl/quplsDecodeRs.sv
// Source register decode
// Selects ra and rb, sets their use flags and banks the stack pointer

`timescale 1ns/100ps

module quplsDecodeRs
	import quplsDecodePkg::*;
(
	input  operating_mode_t om,
	input  logic [2:0]      ipl,
	input  instruction_t    instr,
	output aregno_t         ra,
	output aregno_t         rb,
	output logic            usesRa,
	output logic            usesRb
);

	aregno_t rbField;

	// ra is read by every opcode except these three
	always_comb
	begin
		case (instr.opcode)
		OP_NOP, OP_BSR, OP_RTD:
			usesRa = 1'b0;
		default:
			usesRa = 1'b1;
		endcase
	end

	// Only register to register ops and stores read a second register
	always_comb
	begin
		case (instr.opcode)
		OP_R2, OP_STO:
			usesRb = 1'b1;
		default:
			usesRb = 1'b0;
		endcase
	end

	// A store carries its data register in the rt field
	assign rbField = (instr.opcode == OP_STO) ? {1'b0, instr.rt} : {1'b0, instr.rb};

	// Unused sources read as register 0 so the renamer sees no dependency
	assign ra = usesRa ? fnBankReg({1'b0, instr.ra}, om, ipl) : 6'd0;
	assign rb = usesRb ? fnBankReg(rbField, om, ipl) : 6'd0;

endmodule

// File: rtl/quplsDecodeRt.sv
// Target register decode
// Picks the written register by opcode and function code
// Applies stack pointer banking and flags a register 0 target

`timescale 1ns/100ps

module quplsDecodeRt
	import quplsDecodePkg::*;
(
	input  operating_mode_t om,
	input  logic [2:0]      ipl,
	input  instruction_t    instr,
	output aregno_t         rt,
	output logic            rtz
);

	aregno_t rtRaw;

	// Architectural target before banking
	// Register 0 stands for no write
	function automatic aregno_t fnRt(input instruction_t ir);
		case (ir.opcode)
		OP_R2:
			case (ir.func)
			FN_ADD:  fnRt = {1'b0, ir.rt};
			FN_SUB:  fnRt = {1'b0, ir.rt};
			FN_AND:  fnRt = {1'b0, ir.rt};
			FN_OR:   fnRt = {1'b0, ir.rt};
			FN_EOR:  fnRt = {1'b0, ir.rt};
			FN_SLT:  fnRt = {1'b0, ir.rt};
			FN_MUL:  fnRt = {1'b0, ir.rt};
			// Unknown function codes write nothing
			default: fnRt = 6'd0;
			endcase
		OP_ADDI, OP_ANDI, OP_ORI:
			fnRt = {1'b0, ir.rt};
		OP_LDO:
			fnRt = {1'b0, ir.rt};
		// Link register lives in the rt field
		OP_BSR:
			fnRt = {1'b0, ir.rt};
		// Decrement and branch writes the counter back to ra
		OP_BCC:
			fnRt = ir.rt[0] ? {1'b0, ir.ra} : 6'd0;
		// Return and deallocate adjusts the stack pointer
		OP_RTD:
			fnRt = SP_REG;
		// Stores, no-ops and unknown opcodes
		default:
			fnRt = 6'd0;
		endcase
	endfunction

	assign rtRaw = fnRt(instr);

	// Stack pointer is banked by mode, or by level in machine mode
	assign rt = fnBankReg(rtRaw, om, ipl);

	// No write when the target is register 0
	assign rtz = (rt == 6'd0);

	// Banking leaves no path for register 31 to reach the rename stage
	always_comb
	begin
		assert (rt != SP_REG)
		else $error("unbanked stack pointer in target decode");
	end

endmodule

// File: rtl/quplsFetch.sv
// Sequential instruction fetch over a Wishbone classic master port
// Program counter and bus busy state
// Pipeline register holding the fetched word and its address
// Bus protocol checks

`timescale 1ns/100ps

module quplsFetch
	import quplsDecodePkg::*;
(
	input  logic        clk,
	input  logic        rstN,
	output logic        wbCyc,
	output logic        wbStb,
	output logic        wbWe,
	output logic [3:0]  wbSel,
	output logic [31:0] wbAdr,
	input  logic [31:0] wbDatI,
	input  logic        wbAck,
	output logic        fetchValid,
	input  logic        fetchReady,
	output fetchPkt_t   fetchPkt
);

	logic [31:0] pcQ;
	logic        busyQ;
	logic        regReady;
	logic        wordDone;
	fetchPkt_t   fetchIn;

	// The cycle ends in the clock where the slave acknowledges
	assign wordDone = busyQ && wbAck;

	// ==============================
	// Bus cycle control
	// ==============================

	// A new cycle starts only when the register is empty or draining
	// Nothing else fills the register, so it is still free when the ack arrives
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busyQ <= 1'b0;
			pcQ <= RESET_PC;
		end
		else if (wordDone)
		begin
			busyQ <= 1'b0;
			pcQ <= pcQ + 32'd4;
		end
		else if (!busyQ && regReady)
			busyQ <= 1'b1;
	end

	// Read only master with full word lanes
	assign wbCyc = busyQ;
	assign wbStb = busyQ;
	assign wbWe = 1'b0;
	assign wbSel = 4'hF;
	// Address comes straight from the pc, which only moves on ack
	assign wbAdr = pcQ;

	// The fetched word is paired with the address it came from
	assign fetchIn.pc = pcQ;
	assign fetchIn.instr = wbDatI;

	quplsPipeReg #(
		.payloadT(fetchPkt_t)
	) fetchReg (
		.clk(clk),
		.rstN(rstN),
		.inValid(wordDone),
		.inReady(regReady),
		.inData(fetchIn),
		.outValid(fetchValid),
		.outReady(fetchReady),
		.outData(fetchPkt)
	);

	// ==============================
	// Protocol checks
	// ==============================

	// An ack outside an open strobe would never reach the register
	assert property (@(posedge clk) disable iff (!rstN) wbAck |-> (wbCyc && wbStb))
	else $error("wbAck without an open strobe");

	// While waiting for ack the cycle is held and the address does not move
	assert property (@(posedge clk) disable iff (!rstN)
		(wbCyc && !wbAck) |=> (wbCyc && $stable(wbAdr)))
	else $error("bus cycle dropped or address changed before ack");

endmodule

// File: rtl/quplsPipeReg.sv
// One entry valid/ready pipeline register
// The payload type is a parameter so fetch and decode share it
// Includes a stall stability check on the output

`timescale 1ns/100ps

module quplsPipeReg #(
	parameter type payloadT = logic
)
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    inValid,
	output logic    inReady,
	input  payloadT inData,
	output logic    outValid,
	input  logic    outReady,
	output payloadT outData
);

	logic    fullQ;
	payloadT dataQ;

	// Accept when empty or when the held entry leaves in this cycle
	assign inReady = !fullQ || outReady;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			fullQ <= 1'b0;
		else if (inReady)
			fullQ <= inValid;
	end

	// The payload is captured on every accepted transfer
	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
			dataQ <= inData;
	end

	assign outValid = fullQ;
	assign outData = dataQ;

	// A stalled entry stays valid and unchanged into the next cycle
	assert property (@(posedge clk) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outData)))
	else $error("pipeline register changed while stalled");

endmodule

// File: rtl/quplsDecodePkg.sv
// Shared definitions for the fetch and decode front end
// Opcode and function code enumerations
// Instruction field layout and register number types
// Fetch and decode packet structs
// Stack pointer banking function used by both register decoders

package quplsDecodePkg;

	// ==============================
	// Constants
	// ==============================

	// Architectural stack pointer before banking
	localparam logic [5:0] SP_REG = 6'd31;
	// First instruction address after reset
	localparam logic [31:0] RESET_PC = 32'h0000_0000;
	// Machine mode selects the per interrupt level stack pointers
	localparam logic [1:0] MACHINE_MODE = 2'd3;
	// Base numbers of the two stack pointer banks
	localparam logic [5:0] SP_IPL_BASE = 6'd32;
	localparam logic [5:0] SP_OM_BASE = 6'd40;

	// ==============================
	// Encodings
	// ==============================

	typedef enum logic [6:0] {
		OP_R2   = 7'd2,
		OP_ADDI = 7'd4,
		OP_ANDI = 7'd8,
		OP_ORI  = 7'd9,
		OP_BSR  = 7'd32,
		OP_RTD  = 7'd35,
		OP_BCC  = 7'd40,
		OP_LDO  = 7'd70,
		OP_STO  = 7'd86,
		OP_NOP  = 7'd127
	} opcode_t;

	// Function codes of R2 format instructions
	typedef enum logic [6:0] {
		FN_ADD = 7'd4,
		FN_SUB = 7'd5,
		FN_AND = 7'd8,
		FN_OR  = 7'd9,
		FN_EOR = 7'd10,
		FN_MUL = 7'd16,
		FN_SLT = 7'd18
	} func_t;

	// One 32-bit instruction, most significant field first
	// For OP_BCC the lowest bit of rt is the decrement flag
	typedef struct packed {
		func_t      func;
		logic [2:0] unused;
		logic [4:0] rb;
		logic [4:0] ra;
		logic [4:0] rt;
		opcode_t    opcode;
	} instruction_t;

	// Expanded register number
	// 0 to 31 general, 32 to 39 per level stack pointers, 40 to 43 per mode stack pointers
	typedef logic [5:0] aregno_t;
	typedef logic [1:0] operating_mode_t;

	// ==============================
	// Packets
	// ==============================

	typedef struct packed {
		logic [31:0]  pc;
		instruction_t instr;
	} fetchPkt_t;

	typedef struct packed {
		logic [31:0] pc;
		opcode_t     opcode;
		aregno_t     rt;
		aregno_t     ra;
		aregno_t     rb;
		logic        rtz;
		logic        usesRa;
		logic        usesRb;
	} decodePkt_t;

	// Register 31 is replaced by the stack pointer of the current mode
	// In machine mode the interrupt level picks one of eight stack pointers
	function automatic aregno_t fnBankReg(
		input aregno_t regNo,
		input operating_mode_t om,
		input logic [2:0] ipl
	);
		if (regNo != SP_REG)
			return regNo;
		else if (om == MACHINE_MODE)
			return SP_IPL_BASE + {3'd0, ipl};
		else
			return SP_OM_BASE + {4'd0, om};
	endfunction

endpackage
